/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tbReshapeConcat
RTL_TOP    := reshapeConcatTop
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then with the testbench around it
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) src/*.sv src/*.svh testbench/*.sv
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
+incdir+src
src/reshapeCmdPkg.sv
src/reshapeDataPkg.sv
src/reshapeInstrLatch.sv
src/concatSequencer.sv
src/concatRequant.sv
src/reshapeConcatTop.sv
testbench/tbReshapeConcat.sv

/* src/concatRequant.sv */
`timescale 1ns/1ns
`default_nettype none
`include "reshape_settings.svh"

module concatRequant
    import reshapeDataPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       inValid,
    input  logic       inPop,
    input  logic       pipeValid,
    input  concatSrc   pipeSrc,
    input  elemT       inData,
    input  scaleT      scale1,
    input  scaleT      scale2,
    input  zeroPointT  zeroPoint1,
    input  zeroPointT  zeroPoint2,
    output logic       outValid,
    output elemT       outData
);
    localparam int Depth   = `RESHAPE_IN_CREDITS;
    localparam int PtrW    = $clog2(Depth);
    localparam int FracW   = 16;

    // Parked inputs, one slot per upstream credit
    elemT                parkMem [Depth];
    logic [PtrW-1:0]     wrPtr;
    logic [PtrW-1:0]     rdPtr;

    logic signed [15:0]  selZp;
    scaleT               selScale;
    logic signed [16:0]  diffNext;
    logic                s1Valid;
    logic signed [16:0]  s1Diff;
    scaleT               s1Scale;
    logic signed [49:0]  prod;
    logic signed [49:0]  shifted;

    always_ff @(posedge clk) begin
        if (inValid) begin
            parkMem[wrPtr] <= inData;
        end
    end

    // Pointers wrap at the store depth
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (inValid) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (inPop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    // Stage 1: pick the source parameters and remove the zero point
    assign selZp    = (pipeSrc == SrcFirst) ? zeroPoint1[15:0] : zeroPoint2[15:0];
    assign selScale = (pipeSrc == SrcFirst) ? scale1 : scale2;
    assign diffNext = 17'(parkMem[rdPtr]) - 17'(selZp);

    always_ff @(posedge clk) begin
        s1Diff  <= diffNext;
        s1Scale <= selScale;
    end

    // Stage 2: scale, round to nearest, back to integer
    assign prod    = 50'(s1Diff) * 50'(s1Scale) + 50'(`RESHAPE_ROUND);
    assign shifted = prod >>> FracW;

    always_ff @(posedge clk) begin
        // Clamp to int8
        if (shifted > 50'sd127) begin
            outData <= 8'sd127;
        end else if (shifted < -50'sd128) begin
            outData <= -8'sd128;
        end else begin
            outData <= shifted[7:0];
        end
    end

    // Fixed two-cycle latency, never stalls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            s1Valid  <= pipeValid;
            outValid <= s1Valid;
        end
    end

endmodule

`default_nettype wire

/* src/concatSequencer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "reshape_settings.svh"

module concatSequencer
    import reshapeCmdPkg::*;
    import reshapeDataPkg::*;
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       launch,
    input  reshapeOp                   op,
    input  logic [`RESHAPE_ROW_W-1:0]  rowNumIn,
    input  logic [`RESHAPE_ROW_W-1:0]  rowNumOut,
    input  logic [`RESHAPE_CH_W-1:0]   channelInNum,
    input  logic [`RESHAPE_CH_W-1:0]   channelRamNum,
    input  logic                       inValid,
    input  logic                       outCredit,
    output logic                       inCredit,
    output logic                       inPop,
    output logic                       pipeValid,
    output concatSrc                   pipeSrc,
    output logic                       busy,
    output logic                       done
);
    seqState                     state;
    logic [`RESHAPE_ROW_W-1:0]   rowIdx;
    logic [`RESHAPE_CH_W:0]      chIdx;
    logic [`RESHAPE_CH_W:0]      chTotal;
    logic [`RESHAPE_CRED_W-1:0]  outCred;
    logic [`RESHAPE_CRED_W-1:0]  parkCount;
    logic                        flushCnt;
    logic                        emptyJob;
    logic                        emitElem;
    logic                        pop;
    logic                        lastCh;
    logic                        lastRow;

    // Elements per row, both sources
    assign chTotal  = {1'b0, channelInNum} + {1'b0, channelRamNum};
    // Nothing to walk, finish right away
    assign emptyJob = (op == OpNop) || (op == OpStoreOnly)
                      || (rowNumIn == '0) || (chTotal == '0);
    // Only kept rows of a concat job produce output
    assign emitElem = (op == OpConcat) && (rowIdx < rowNumOut);
    // Take a parked element, reserve an outbound credit first if it will be emitted
    assign pop = (state == SeqRun) && !emptyJob && (parkCount != '0)
                 && (!emitElem || (outCred != '0));

    assign inPop     = pop;
    assign pipeValid = pop && emitElem;
    // Source 1 owns the first channelInNum slots of each row
    assign pipeSrc   = (chIdx < {1'b0, channelInNum}) ? SrcFirst : SrcSecond;
    assign lastCh    = (chIdx == chTotal - 1'b1);
    assign lastRow   = (rowIdx == rowNumIn - 1'b1);
    assign busy      = (state != SeqIdle);

    // Outbound credits: spent on accept, returned by downstream
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outCred <= `RESHAPE_CRED_W'(`RESHAPE_OUT_CREDITS);
        end else if (pipeValid && !outCredit) begin
            outCred <= outCred - 1'b1;
        end else if (!pipeValid && outCredit) begin
            outCred <= outCred + 1'b1;
        end
    end

    // Parked elements waiting in the requant input store
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            parkCount <= '0;
        end else if (inValid && !pop) begin
            parkCount <= parkCount + 1'b1;
        end else if (!inValid && pop) begin
            parkCount <= parkCount - 1'b1;
        end
    end

    // One credit back upstream per consumed element, kept or cropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inCredit <= 1'b0;
        end else begin
            inCredit <= pop;
        end
    end

    // Main FSM with row and channel walk
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= SeqIdle;
            rowIdx   <= '0;
            chIdx    <= '0;
            flushCnt <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                SeqIdle: begin
                    if (launch) begin
                        state    <= SeqRun;
                        rowIdx   <= '0;
                        chIdx    <= '0;
                        flushCnt <= 1'b0;
                    end
                end
                SeqRun: begin
                    if (emptyJob) begin
                        state <= SeqIdle;
                        done  <= 1'b1;
                    end else if (pop) begin
                        if (lastCh) begin
                            chIdx  <= '0;
                            rowIdx <= rowIdx + 1'b1;
                            // Last element of the job is in
                            if (lastRow) begin
                                state <= SeqFlush;
                            end
                        end else begin
                            chIdx <= chIdx + 1'b1;
                        end
                    end
                end
                SeqFlush: begin
                    // Two cycles for the requant to drain
                    if (flushCnt) begin
                        state <= SeqIdle;
                        done  <= 1'b1;
                    end
                    flushCnt <= ~flushCnt;
                end
                default: begin
                    state <= SeqIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/reshapeCmdPkg.sv */
`default_nettype none

package reshapeCmdPkg;

    // Instruction opcode, bit 1 is writeDdr and bit 0 is readDdr
    typedef enum logic [1:0] {
        // No traffic at all
        OpNop       = 2'b00,
        // Consume the input stream, emit nothing
        OpDrain     = 2'b01,
        // Store without read, handled as a nop here
        OpStoreOnly = 2'b10,
        // Read, requantize and write
        OpConcat    = 2'b11
    } reshapeOp;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SeqIdle  = 2'd0,
        SeqRun   = 2'd1,
        SeqFlush = 2'd2
    } seqState;

endpackage

`default_nettype wire

/* src/reshapeConcatTop.sv */
`timescale 1ns/1ns
`default_nettype none
`include "reshape_settings.svh"

module reshapeConcatTop
    import reshapeCmdPkg::*;
    import reshapeDataPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         start,
    input  logic [31:0]  reg4,
    input  logic [31:0]  reg5,
    input  logic [31:0]  reg6,
    input  logic [31:0]  reg7,
    input  logic [31:0]  reg8,
    input  logic [31:0]  reg9,
    input  logic         inValid,
    input  elemT         inData,
    input  logic         outCredit,
    output logic         inCredit,
    output logic         outValid,
    output elemT         outData,
    output logic         busy,
    output logic         done
);
    reshapeOp                    op;
    logic [`RESHAPE_ROW_W-1:0]   rowNumIn;
    logic [`RESHAPE_ROW_W-1:0]   rowNumOut;
    logic [`RESHAPE_CH_W-1:0]    channelInNum;
    logic [`RESHAPE_CH_W-1:0]    channelRamNum;
    scaleT                       scale1;
    scaleT                       scale2;
    zeroPointT                   zeroPoint1;
    zeroPointT                   zeroPoint2;
    logic                        launch;
    logic                        inPop;
    logic                        pipeValid;
    concatSrc                    pipeSrc;

    // A start during a running job is ignored
    assign launch = start && !busy;

    reshapeInstrLatch u_instrLatch (
        .clk           (clk),
        .arstN         (arstN),
        .start         (start),
        .busy          (busy),
        .reg4          (reg4),
        .reg5          (reg5),
        .reg6          (reg6),
        .reg7          (reg7),
        .reg8          (reg8),
        .reg9          (reg9),
        .op            (op),
        .rowNumIn      (rowNumIn),
        .rowNumOut     (rowNumOut),
        .channelInNum  (channelInNum),
        .channelRamNum (channelRamNum),
        .scale1        (scale1),
        .scale2        (scale2),
        .zeroPoint1    (zeroPoint1),
        .zeroPoint2    (zeroPoint2)
    );

    // Decides acceptance, owns both credit counters
    concatSequencer u_sequencer (
        .clk           (clk),
        .arstN         (arstN),
        .launch        (launch),
        .op            (op),
        .rowNumIn      (rowNumIn),
        .rowNumOut     (rowNumOut),
        .channelInNum  (channelInNum),
        .channelRamNum (channelRamNum),
        .inValid       (inValid),
        .outCredit     (outCredit),
        .inCredit      (inCredit),
        .inPop         (inPop),
        .pipeValid     (pipeValid),
        .pipeSrc       (pipeSrc),
        .busy          (busy),
        .done          (done)
    );

    // Input store plus requant pipe, output straight to the port
    concatRequant u_requant (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .inPop      (inPop),
        .pipeValid  (pipeValid),
        .pipeSrc    (pipeSrc),
        .inData     (inData),
        .scale1     (scale1),
        .scale2     (scale2),
        .zeroPoint1 (zeroPoint1),
        .zeroPoint2 (zeroPoint2),
        .outValid   (outValid),
        .outData    (outData)
    );

endmodule

`default_nettype wire

/* src/reshapeDataPkg.sv */
`default_nettype none

package reshapeDataPkg;

    // Quantized activation
    typedef logic signed [7:0] elemT;

    // Multiplier in Q16
    typedef logic signed [31:0] scaleT;

    // Only the low 16 bits take part in the requant
    typedef logic signed [31:0] zeroPointT;

    // Which half of the row an element belongs to
    typedef enum logic {
        SrcFirst  = 1'b0,
        SrcSecond = 1'b1
    } concatSrc;

endpackage

`default_nettype wire

/* src/reshapeInstrLatch.sv */
`timescale 1ns/1ns
`default_nettype none
`include "reshape_settings.svh"

module reshapeInstrLatch
    import reshapeCmdPkg::*;
    import reshapeDataPkg::*;
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       start,
    input  logic                       busy,
    input  logic [31:0]                reg4,
    input  logic [31:0]                reg5,
    input  logic [31:0]                reg6,
    input  logic [31:0]                reg7,
    input  logic [31:0]                reg8,
    input  logic [31:0]                reg9,
    output reshapeOp                   op,
    output logic [`RESHAPE_ROW_W-1:0]  rowNumIn,
    output logic [`RESHAPE_ROW_W-1:0]  rowNumOut,
    output logic [`RESHAPE_CH_W-1:0]   channelInNum,
    output logic [`RESHAPE_CH_W-1:0]   channelRamNum,
    output scaleT                      scale1,
    output scaleT                      scale2,
    output zeroPointT                  zeroPoint1,
    output zeroPointT                  zeroPoint2
);
    // All six words, reg9 in the top slot
    logic [191:0] instr;

    // Capture once per job, a start during a job is dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr <= '0;
        end else if (start && !busy) begin
            instr <= {reg9, reg8, reg7, reg6, reg5, reg4};
        end
    end

    // reg4: source 1 channels, writeDdr and readDdr flags
    assign channelInNum  = instr[31:22];
    assign op            = reshapeOp'(instr[1:0]);
    // reg5: row and source 2 channel counts
    assign rowNumIn      = instr[63:53];
    assign channelRamNum = instr[52:43];
    assign rowNumOut     = instr[42:32];
    // reg6 to reg9: per-source requant parameters
    assign scale1        = instr[95:64];
    assign scale2        = instr[127:96];
    assign zeroPoint1    = instr[159:128];
    assign zeroPoint2    = instr[191:160];

endmodule

`default_nettype wire

/* src/reshape_settings.svh */
`ifndef RESHAPE_SETTINGS_SVH
`define RESHAPE_SETTINGS_SVH

// Row counts, rowNumIn and rowNumOut
`define RESHAPE_ROW_W 11

// Channel counts per concat source
`define RESHAPE_CH_W 10

// Credits upstream starts with
// Also the depth of the parked-input store
`define RESHAPE_IN_CREDITS 4

// Credits the engine holds toward downstream
`define RESHAPE_OUT_CREDITS 4

// Credit and occupancy counter width, must hold the value 4
`define RESHAPE_CRED_W 3

// Half an LSB in Q16, added before the shift
`define RESHAPE_ROUND 32768

`endif

/* testbench/reshape_golden.hex */
// Job count first, then per job: nIn nOut holdCycles flags / reg4 to reg9 /
// nIn input bytes / nOut expected bytes. Flags bit 0 repeats start mid-job
4
// Concat, 2 rows of 3 + 2 channels, saturates at both ends
0A 0A 00 01
00C00003 00401002 00018000 00030000 FFFF0005 0000FFF6
10 7F 80 05 F0 00 FB 2A 40 C4
11 7F 80 2D EE F9 F1 38 7F 80
// Concat with the third row cropped, credits held for 30 cycles
0C 08 1E 00
00800003 00601002 00008000 FFFF0000 00000000 00000003
14 03 0A 80 FD 7F 7F 00 11 22 33 44
0A 02 F9 7F FF 40 84 03
// Drain, 2 rows of 1 + 2 channels, nothing comes out
06 00 00 00
00400001 00401002 00000000 00000000 00000000 00000000
01 02 03 04 05 06
// Nop, no traffic at all
00 00 00 00
00C00000 00401002 00000000 00000000 00000000 00000000

/* testbench/tbReshapeConcat.sv */
`timescale 1ns/1ns
`default_nettype none
`include "reshape_settings.svh"

module tbReshapeConcat;

    logic         clk;
    logic         arstN;
    logic         start;
    logic [31:0]  reg4;
    logic [31:0]  reg5;
    logic [31:0]  reg6;
    logic [31:0]  reg7;
    logic [31:0]  reg8;
    logic [31:0]  reg9;
    logic         inValid;
    logic [7:0]   inData;
    logic         outCredit;
    logic         inCredit;
    logic         outValid;
    logic [7:0]   outData;
    logic         busy;
    logic         done;

    // Golden words, walked job by job through rdIdx
    logic [31:0]  golden [0:255];
    int           rdIdx;
    int           cycle;
    int           cycleLimit;
    int           errors;
    int           compared;
    int           upCredits;
    int           outSeen;
    int           credReturned;
    int           inCreditCount;
    int           doneCount;
    int           holdUntil;
    bit           jobLive;
    logic [31:0]  rngState;
    logic [7:0]   inQ [$];
    logic [7:0]   expQ [$];
    // Cycles at which outbound credits go back
    int           retQ [$];

    reshapeConcatTop u_reshapeConcatTop (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .reg4      (reg4),
        .reg5      (reg5),
        .reg6      (reg6),
        .reg7      (reg7),
        .reg8      (reg8),
        .reg9      (reg9),
        .inValid   (inValid),
        .inData    (inData),
        .outCredit (outCredit),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outData   (outData),
        .busy      (busy),
        .done      (done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic finishRun();
        $display("Summary: %0d outputs compared, %0d errors", compared, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // One clock: sample settled outputs, then drive both credit models
    task automatic stepCycle();
        logic [7:0] expVal;
        @(posedge clk);
        #1;
        cycle++;
        if (inCredit) begin
            upCredits++;
            inCreditCount++;
        end
        if (done) begin
            doneCount++;
        end
        assert (upCredits <= `RESHAPE_IN_CREDITS) else begin
            errors++;
            $display("More inbound credits came back than were spent, cycle %0d", cycle);
        end
        if (jobLive) begin
            assert (busy || done) else begin
                errors++;
                $display("busy dropped before done at cycle %0d", cycle);
            end
        end else begin
            assert (!busy && !done && !outValid && !inCredit) else begin
                errors++;
                $display("Activity at cycle %0d while no job was running", cycle);
            end
        end
        if (outValid) begin
            outSeen++;
            assert (outSeen <= `RESHAPE_OUT_CREDITS + credReturned) else begin
                errors++;
                $display("outValid at cycle %0d arrived without an outbound credit", cycle);
            end
            assert (expQ.size() > 0) else begin
                errors++;
                $display("outValid at cycle %0d with no output left to expect", cycle);
            end
            if (expQ.size() > 0) begin
                expVal = expQ.pop_front();
                compared++;
                assert (outData === expVal) else begin
                    errors++;
                    $display("FAIL outData: got %h, expected %h", outData, expVal);
                end
            end
            retQ.push_back(cycle + int'(nextRandom() & 32'd3));
        end
        // Downstream, one credit per cycle once due and not held back
        outCredit = 1'b0;
        if (retQ.size() > 0 && retQ[0] <= cycle && cycle >= holdUntil) begin
            void'(retQ.pop_front());
            outCredit = 1'b1;
            credReturned++;
        end
        // Upstream sends only while it holds a credit
        inValid = 1'b0;
        if (upCredits > 0 && inQ.size() > 0) begin
            inValid = 1'b1;
            inData = inQ.pop_front();
            upCredits--;
        end
    endtask

    task automatic runJob(input int jobNum);
        int          nIn;
        int          nOut;
        int          hold;
        logic [31:0] flags;
        int          doneBefore;
        int          creditsBefore;
        int          k;
        nIn   = int'(golden[rdIdx]);
        nOut  = int'(golden[rdIdx + 1]);
        hold  = int'(golden[rdIdx + 2]);
        flags = golden[rdIdx + 3];
        reg4  = golden[rdIdx + 4];
        reg5  = golden[rdIdx + 5];
        reg6  = golden[rdIdx + 6];
        reg7  = golden[rdIdx + 7];
        reg8  = golden[rdIdx + 8];
        reg9  = golden[rdIdx + 9];
        rdIdx += 10;
        for (int i = 0; i < nIn; i++) begin
            inQ.push_back(golden[rdIdx + i][7:0]);
        end
        rdIdx += nIn;
        for (int i = 0; i < nOut; i++) begin
            expQ.push_back(golden[rdIdx + i][7:0]);
        end
        rdIdx += nOut;
        doneBefore    = doneCount;
        creditsBefore = inCreditCount;
        // Credits stay with downstream for the first hold cycles
        holdUntil = cycle + hold;
        jobLive = 1'b1;
        start = 1'b1;
        stepCycle();
        k = 0;
        while (doneCount == doneBefore) begin
            // Second start with other fields, must be ignored
            start = flags[0] && (k == 3);
            if (start) begin
                reg4 = 32'h0040_0001;
                reg5 = 32'h0020_0801;
            end
            stepCycle();
            k++;
        end
        start = 1'b0;
        jobLive = 1'b0;
        assert (expQ.size() == 0) else begin
            errors++;
            $display("Job %0d ended with %0d outputs missing", jobNum, expQ.size());
        end
        assert (inCreditCount - creditsBefore == nIn) else begin
            errors++;
            $display("FAIL inCredit pulses: got %h, expected %h",
                     inCreditCount - creditsBefore, nIn);
        end
        // All outbound credits home before the next job
        while (retQ.size() > 0) begin
            stepCycle();
        end
        repeat (3) stepCycle();
    endtask

    initial begin
        int jobCount;
        int elems;
        int p;
        clk       = 1'b0;
        arstN     = 1'b0;
        start     = 1'b0;
        reg4      = '0;
        reg5      = '0;
        reg6      = '0;
        reg7      = '0;
        reg8      = '0;
        reg9      = '0;
        inValid   = 1'b0;
        inData    = '0;
        outCredit = 1'b0;
        rngState  = 32'h45b7_61cf;
        cycle         = 0;
        errors        = 0;
        compared      = 0;
        upCredits     = `RESHAPE_IN_CREDITS;
        outSeen       = 0;
        credReturned  = 0;
        inCreditCount = 0;
        doneCount     = 0;
        holdUntil     = 0;
        jobLive       = 1'b0;
        $readmemh("testbench/reshape_golden.hex", golden);
        jobCount = int'(golden[0]);
        // Run budget, 40 cycles per input or output element
        elems = 0;
        p = 1;
        for (int j = 0; j < jobCount; j++) begin
            elems += int'(golden[p] + golden[p + 1]);
            p += 10 + int'(golden[p] + golden[p + 1]);
        end
        cycleLimit = 40 * elems + 200;
        rdIdx = 1;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
        // Outputs quiet before the first start
        repeat (4) stepCycle();
        for (int j = 1; j <= jobCount; j++) begin
            runJob(j);
        end
        finishRun();
    end

    // Watchdog
    initial begin
        #1;
        for (int n = 0; n < cycleLimit; n++) begin
            @(posedge clk);
        end
        errors++;
        $display("Timeout after %0d cycles, a job never finished", cycleLimit);
        finishRun();
    end

endmodule

`default_nettype wire
